//--- Bender.yml
package:
  name: zports

sources:
  - include_dirs:
      - include
    files:
      - design/zports_pkg.sv
      - design/io_access_if.sv
      - design/port_decode.sv
      - design/port_regs.sv
      - design/read_mux.sv
      - design/zports.sv
  - target: test
    include_dirs:
      - include
    files:
      - testbench/zports_props.sv
      - testbench/zports_tb.sv

//--- design/io_access_if.sv
`timescale 1ns/1ps

// one decoded z80 port access
interface io_access_if;

	logic                wr_stb;     // single cycle, new write
	logic                rd_stb;     // single cycle, new read
	logic                rd_active;  // read in progress, level
	zports_pkg::port_e   port;       // live decode of the address
	logic [7:0]          data;       // live bus data

	modport decoder (output wr_stb, rd_stb, rd_active, port, data);

	modport execute (input wr_stb, port, data);

	modport result (input rd_stb, rd_active, port);

endinterface

//--- design/port_decode.sv
`timescale 1ns/1ps

`include "zports_defs.svh"

module port_decode
(
	input  logic               zclk,
	input  logic               rst_n,
	input  logic [15:0]        a,
	input  logic               iorq_n,
	input  logic               rd_n,
	input  logic               wr_n,
	input  logic               dos,
	input  logic [7:0]         din,
	io_access_if.decoder       acc
);

	logic       io_wr;      // write cycle on the bus now
	logic       io_rd;
	logic       io_wr_q;    // same, one cycle back
	logic       io_rd_q;
	logic       wr_stb_q;
	logic       rd_stb_q;
	logic [7:0] loa;

	assign io_wr = ~iorq_n & ~wr_n;
	assign io_rd = ~iorq_n & ~rd_n;
	assign loa   = a[7:0];

	////////////////////////////////////////////////////////////////////////////
	// access strobes
	////////////////////////////////////////////////////////////////////////////

	// strobe on the first sampled cycle of an access, then wait for release
	always_ff @(posedge zclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			io_wr_q  <= 1'b0;
			io_rd_q  <= 1'b0;
			wr_stb_q <= 1'b0;
			rd_stb_q <= 1'b0;
		end
		else
		begin
			io_wr_q  <= io_wr;
			io_rd_q  <= io_rd;
			wr_stb_q <= io_wr & ~io_wr_q;
			rd_stb_q <= io_rd & ~io_rd_q;
		end
	end

	assign acc.wr_stb    = wr_stb_q;
	assign acc.rd_stb    = rd_stb_q;
	assign acc.rd_active = io_rd;
	assign acc.data      = din;

	////////////////////////////////////////////////////////////////////////////
	// address decode
	////////////////////////////////////////////////////////////////////////////

	always_comb
	begin
		acc.port = zports_pkg::PORT_NONE;

		// xt ports need the whole address
		if (a == `ZP_XT_ADDR)
			acc.port = zports_pkg::PORT_XT_ADDR;
		else if (a == `ZP_XT_DATA)
			acc.port = zports_pkg::PORT_XT_DATA;
		else
		begin
			case (loa)
				`ZP_PORT_FE:
					acc.port = zports_pkg::PORT_FE;
				`ZP_PORT_FD:
					acc.port = a[15] ? zports_pkg::PORT_FD_OTHER : zports_pkg::PORT_7FFD;
				`ZP_PORT_F7:
				begin
					if (!dos)  // hidden while shadow is on
						acc.port = a[12] ? zports_pkg::PORT_F7_OTHER : zports_pkg::PORT_EFF7;
				end
				`ZP_PORT_CVX:
					acc.port = zports_pkg::PORT_CVX;
				`ZP_PORT_KJOY:
				begin
					if (!dos)  // vg93 command port in shadow
						acc.port = zports_pkg::PORT_KJOY;
				end
				`ZP_PORT_MOUSE:
					acc.port = zports_pkg::PORT_MOUSE;
				default:
					acc.port = zports_pkg::PORT_NONE;
			endcase
		end
	end

endmodule

//--- design/port_regs.sv
`timescale 1ns/1ps

`include "zports_defs.svh"

module port_regs
(
	input  logic                    zclk,
	input  logic                    rst_n,
	io_access_if.execute            acc,
	output logic [`ZP_BORDER_W-1:0] border,
	output logic [7:0]              cvx,
	output logic [7:0]              p7ffd,
	output logic [7:0]              peff7,
	output logic [5:0]              pent1m_page,
	output logic                    pent1m_1m_on,
	output logic [7:0]              vcfg,
	output logic [7:0]              sp_wa,
	output logic                    sp_we
);

	logic [`ZP_DATA_W-1:0] d;
	logic [7:0]            p7ffd_r;
	logic [7:0]            peff7_r;
	logic [7:0]            xt_addr;    // selected xt register
	logic                  block1m;    // eff7 bit2, 1 MB mode off
	logic                  block7ffd;  // 48k lock in 128k mode
	logic                  wr_fe;
	logic                  wr_cvx;
	logic                  wr_7ffd;
	logic                  wr_eff7;
	logic                  wr_xt_addr;
	logic                  wr_xt_data;

	assign d = acc.data;

	assign wr_fe      = acc.wr_stb && (acc.port == zports_pkg::PORT_FE);
	assign wr_cvx     = acc.wr_stb && (acc.port == zports_pkg::PORT_CVX);
	assign wr_7ffd    = acc.wr_stb && (acc.port == zports_pkg::PORT_7FFD);
	assign wr_eff7    = acc.wr_stb && (acc.port == zports_pkg::PORT_EFF7);
	assign wr_xt_addr = acc.wr_stb && (acc.port == zports_pkg::PORT_XT_ADDR);
	assign wr_xt_data = acc.wr_stb && (acc.port == zports_pkg::PORT_XT_DATA);

	////////////////////////////////////////////////////////////////////////////
	// paging
	////////////////////////////////////////////////////////////////////////////

	assign block1m   = peff7_r[2];
	assign block7ffd = p7ffd_r[5] & block1m;

	always_ff @(posedge zclk or negedge rst_n)
	begin
		if (!rst_n)
			p7ffd_r <= 8'h00;
		else if (wr_7ffd && !block7ffd)
			p7ffd_r <= d;  // page, screen, rom, lock, high page bits
	end

	always_ff @(posedge zclk or negedge rst_n)
	begin
		if (!rst_n)
			peff7_r <= 8'h00;
		else if (wr_eff7)
			peff7_r <= d;
	end

	// high page bits vanish in 128k mode
	assign p7ffd = {(block1m ? 3'b000 : p7ffd_r[7:5]), p7ffd_r[4:0]};
	assign peff7 = block1m ? {peff7_r[7], 1'b0, peff7_r[5:4], 3'b000, peff7_r[0]} : peff7_r;

	assign pent1m_page  = {p7ffd_r[7:5], p7ffd_r[2:0]};
	assign pent1m_1m_on = ~block1m;

	////////////////////////////////////////////////////////////////////////////
	// border, covox and xt registers
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge zclk or negedge rst_n)
	begin
		if (!rst_n)
			xt_addr <= 8'h00;
		else if (wr_xt_addr)
			xt_addr <= d;
	end

	always_ff @(posedge zclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			border <= '0;
			cvx    <= 8'h00;
			vcfg   <= 8'h00;
			sp_wa  <= 8'h00;
		end
		else
		begin
			if (wr_fe)
			begin
				cvx    <= {d[4], {7{d[3]}}};  // beeper and tape out as dac level
				border <= {d[1], 1'b0, d[2], 1'b0, d[0], 1'b0};
			end

			if (wr_cvx)
				cvx <= d;

			if (wr_xt_data)
			begin
				case (xt_addr)
					zports_pkg::XT_BORDER:
						border <= d[`ZP_BORDER_W-1:0];
					zports_pkg::XT_VCONFIG:
						vcfg <= d;
					zports_pkg::XT_PALADDR:
						sp_wa <= d;
					default:
						;  // paldata goes out as sp_we
				endcase
			end
		end
	end

	// palette ram write, one cycle
	assign sp_we = wr_xt_data && (xt_addr == zports_pkg::XT_PALDATA);

endmodule

//--- design/read_mux.sv
`timescale 1ns/1ps

`include "zports_defs.svh"

module read_mux
(
	io_access_if.result  acc,
	input  logic [4:0]   keys_in,
	input  logic         tape_read,
	input  logic [4:0]   kj_in,
	input  logic [7:0]   mus_in,
	output logic [7:0]   dout,
	output logic         porthit,
	output logic         dataout
);

	// read data for the addressed port
	always_comb
	begin
		case (acc.port)
			zports_pkg::PORT_FE:
				dout = {1'b1, tape_read, 1'b0, keys_in};
			zports_pkg::PORT_KJOY:
				dout = {3'b000, kj_in};
			zports_pkg::PORT_MOUSE:
				dout = mus_in;
			default:
				dout = `ZP_IDLE_BYTE;  // nothing to read back
		endcase
	end

	// any decoded port keeps external devices off the bus
	assign porthit = (acc.port != zports_pkg::PORT_NONE);

	// drive the z80 data bus only while the read lasts
	assign dataout = porthit & acc.rd_active;

endmodule

//--- design/zports.sv
`timescale 1ns/1ps

`include "zports_defs.svh"

module zports
(
	input  logic                    zclk,
	input  logic                    rst_n,

	// z80 bus
	input  logic [15:0]             a,
	input  logic [`ZP_DATA_W-1:0]   din,
	input  logic                    iorq_n,
	input  logic                    rd_n,
	input  logic                    wr_n,
	input  logic                    dos,      // shadow mode

	// read sources
	input  logic [4:0]              keys_in,
	input  logic                    tape_read,
	input  logic [4:0]              kj_in,
	input  logic [7:0]              mus_in,

	output logic [`ZP_DATA_W-1:0]   dout,
	output logic                    porthit,
	output logic                    dataout,

	// write side state
	output logic [`ZP_BORDER_W-1:0] border,
	output logic [7:0]              cvx,
	output logic [7:0]              p7ffd,
	output logic [7:0]              peff7,
	output logic [5:0]              pent1m_page,
	output logic                    pent1m_1m_on,
	output logic [7:0]              vcfg,
	output logic [7:0]              sp_wa,
	output logic                    sp_we
);

	io_access_if acc ();

	port_decode port_decode_inst
	(
		.zclk   (zclk),
		.rst_n  (rst_n),
		.a      (a),
		.iorq_n (iorq_n),
		.rd_n   (rd_n),
		.wr_n   (wr_n),
		.dos    (dos),
		.din    (din),
		.acc    (acc.decoder)
	);

	port_regs port_regs_inst
	(
		.zclk         (zclk),
		.rst_n        (rst_n),
		.acc          (acc.execute),
		.border       (border),
		.cvx          (cvx),
		.p7ffd        (p7ffd),
		.peff7        (peff7),
		.pent1m_page  (pent1m_page),
		.pent1m_1m_on (pent1m_1m_on),
		.vcfg         (vcfg),
		.sp_wa        (sp_wa),
		.sp_we        (sp_we)
	);

	read_mux read_mux_inst
	(
		.acc       (acc.result),
		.keys_in   (keys_in),
		.tape_read (tape_read),
		.kj_in     (kj_in),
		.mus_in    (mus_in),
		.dout      (dout),
		.porthit   (porthit),
		.dataout   (dataout)
	);

endmodule

//--- design/zports_pkg.sv
package zports_pkg;

	// kind of port the current bus address points at
	typedef enum logic [3:0]
	{
		PORT_NONE,
		PORT_FE,
		PORT_7FFD,      // xxFD, a15 low
		PORT_FD_OTHER,  // xxFD, a15 high (ay side)
		PORT_EFF7,      // xxF7 outside shadow, a12 low
		PORT_F7_OTHER,  // xxF7 outside shadow, a12 high
		PORT_CVX,
		PORT_KJOY,
		PORT_MOUSE,
		PORT_XT_ADDR,
		PORT_XT_DATA
	} port_e;

	// register numbers behind 55FF/56FF
	typedef enum logic [7:0]
	{
		XT_BORDER  = 8'h00,
		XT_VCONFIG = 8'h08,
		XT_PALADDR = 8'h09,
		XT_PALDATA = 8'h0A
	} xt_reg_e;

endpackage

//--- include/zports_defs.svh
`ifndef ZPORTS_DEFS_SVH
`define ZPORTS_DEFS_SVH

////////////////////////////////////////////////////////////////////////////
// low address bytes of the decoded ports
////////////////////////////////////////////////////////////////////////////

// beeper, border, keyboard and tape
`define ZP_PORT_FE     8'hFE

// 7FFD paging when a15 is low
`define ZP_PORT_FD     8'hFD

// EFF7 extended paging, outside shadow only
`define ZP_PORT_F7     8'hF7

`define ZP_PORT_CVX    8'hFB    // covox dac
`define ZP_PORT_KJOY   8'h1F    // kempston, outside shadow only
`define ZP_PORT_MOUSE  8'hDF    // kempston mouse

////////////////////////////////////////////////////////////////////////////
// extended register file, full 16-bit decode
////////////////////////////////////////////////////////////////////////////

`define ZP_XT_ADDR     16'h55FF // selects the xt register
`define ZP_XT_DATA     16'h56FF // writes the selected xt register

////////////////////////////////////////////////////////////////////////////
// widths and constants
////////////////////////////////////////////////////////////////////////////

`define ZP_DATA_W      8
`define ZP_BORDER_W    6

// floating bus value for ports without a source
`define ZP_IDLE_BYTE   8'hFF

`endif

//--- testbench/zports_props.sv
`timescale 1ns/1ps

`include "zports_defs.svh"

module zports_props
(
	input logic        zclk,
	input logic        rst_n,
	input logic [15:0] a,
	input logic        iorq_n,
	input logic        wr_n,
	input logic        sp_we,
	input logic        pent1m_1m_on,
	input logic [7:0]  p7ffd,
	input logic [5:0]  pent1m_page
);

	// palette write is a single pulse
	sp_we_single: assert property (@(posedge zclk) disable iff (!rst_n) sp_we |=> !sp_we)
		else $error("sp_we stayed high for two cycles");

	// palette strobe only follows a 56FF bus write
	sp_we_source: assert property (@(posedge zclk) disable iff (!rst_n)
		sp_we |-> $past(!iorq_n && !wr_n && (a == `ZP_XT_DATA)))
		else $error("sp_we without a preceding 56FF write");

	// lock bit sits in pent1m_page[3], paging frozen until 1 MB mode returns
	page_lock: assert property (@(posedge zclk) disable iff (!rst_n)
		(!pent1m_1m_on && pent1m_page[3]) |=>
		(pent1m_1m_on || ($stable(p7ffd) && $stable(pent1m_page))))
		else $error("7FFD paging changed while locked");

endmodule

bind zports zports_props zports_props_inst
(
	.zclk         (zclk),
	.rst_n        (rst_n),
	.a            (a),
	.iorq_n       (iorq_n),
	.wr_n         (wr_n),
	.sp_we        (sp_we),
	.pent1m_1m_on (pent1m_1m_on),
	.p7ffd        (p7ffd),
	.pent1m_page  (pent1m_page)
);

//--- testbench/zports_tb.sv
`timescale 1ns/1ps

`include "zports_defs.svh"

module zports_tb;

	logic        zclk;
	logic        rst_n;
	logic [15:0] a;
	logic [7:0]  din;
	logic        iorq_n, rd_n, wr_n, dos;
	logic [4:0]  keys_in, kj_in;
	logic        tape_read;
	logic [7:0]  mus_in;
	logic [7:0]  dout, cvx, p7ffd, peff7, vcfg, sp_wa;
	logic        porthit, dataout, pent1m_1m_on, sp_we;
	logic [5:0]  border, pent1m_page;
	logic [31:0] lfsr;
	logic [7:0]  exp_peff7;  // last peff7 value the paging test left behind

	zports zports_inst (.*);

	initial
	begin
		zclk = 1'b0;
		forever
			#5 zclk = ~zclk;
	end

	////////////////////////////////////////////////////////////////////////////
	// random bits and result checks
	////////////////////////////////////////////////////////////////////////////

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic rand_bits(input int n, output logic [7:0] v);
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = lfsr_step(lfsr);
			v    = {v[6:0], lfsr[0]};  // one step per bit
		end
	endtask

	task automatic stop_run(input string msg);
		$display("%s", msg);
		$display("TEST FAIL");
		$fatal(1, "run stopped");
	endtask

	task automatic compare_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
		if (act !== exp)
			stop_run($sformatf("ERR %0t %s expected %h actual %h", $time, name, exp, act));
	endtask

	task automatic compare_border(input string name, input logic [5:0] exp, input logic [5:0] act);
		if (act !== exp)
			stop_run($sformatf("ERR %0t %s expected %h actual %h", $time, name, exp, act));
	endtask

	task automatic compare_bit(input string name, input logic exp, input logic act);
		if (act !== exp)
			stop_run($sformatf("ERR %0t %s expected %b actual %b", $time, name, exp, act));
	endtask

	task automatic compare_page(input string name, input logic [5:0] exp, input logic [5:0] act);
		if (act !== exp)
			stop_run($sformatf("ERR %0t %s expected %h actual %h", $time, name, exp, act));
	endtask

	////////////////////////////////////////////////////////////////////////////
	// z80 bus cycles
	////////////////////////////////////////////////////////////////////////////

	task automatic release_bus();
		iorq_n = 1'b1;
		rd_n   = 1'b1;
		wr_n   = 1'b1;
		a      = 16'h0000;  // low byte 00 decodes to nothing
	endtask

	task automatic io_write(input logic [15:0] addr, input logic [7:0] data);
		@(negedge zclk);
		a      = addr;
		din    = data;
		iorq_n = 1'b0;
		wr_n   = 1'b0;
		repeat (3) @(negedge zclk);
		release_bus();
		repeat (2) @(negedge zclk);
	endtask

	// samples the read mid access
	task automatic io_read(input logic [15:0] addr, output logic [7:0] data,
		output logic hit, output logic drv);
		@(negedge zclk);
		a      = addr;
		iorq_n = 1'b0;
		rd_n   = 1'b0;
		repeat (2) @(negedge zclk);
		data = dout;
		hit  = porthit;
		drv  = dataout;
		@(negedge zclk);
		release_bus();
		repeat (2) @(negedge zclk);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// directed tests
	////////////////////////////////////////////////////////////////////////////

	task automatic test_reset();
		compare_border("border", 6'h00, border);
		compare_byte("cvx", 8'h00, cvx);
		compare_byte("p7ffd", 8'h00, p7ffd);
		compare_byte("peff7", 8'h00, peff7);
		compare_byte("vcfg", 8'h00, vcfg);
		compare_byte("sp_wa", 8'h00, sp_wa);
		compare_page("pent1m_page", 6'h00, pent1m_page);
		compare_bit("pent1m_1m_on", 1'b1, pent1m_1m_on);
		compare_bit("sp_we", 1'b0, sp_we);
		compare_bit("dataout", 1'b0, dataout);
	endtask

	task automatic test_fe();
		logic [7:0] v;
		logic [7:0] rd;
		logic       hit;
		logic       drv;
		rand_bits(8, v);
		io_write({8'h12, `ZP_PORT_FE}, v);
		compare_border("border", {v[1], 1'b0, v[2], 1'b0, v[0], 1'b0}, border);
		compare_byte("cvx", {v[4], {7{v[3]}}}, cvx);
		rand_bits(5, v);
		keys_in = v[4:0];
		rand_bits(1, v);
		tape_read = v[0];
		io_read({8'h34, `ZP_PORT_FE}, rd, hit, drv);
		compare_byte("dout", {1'b1, tape_read, 1'b0, keys_in}, rd);
		compare_bit("porthit", 1'b1, hit);
		compare_bit("dataout", 1'b1, drv);
		rand_bits(8, v);
		io_write({8'h00, `ZP_PORT_CVX}, v);
		compare_byte("cvx", v, cvx);
	endtask

	task automatic test_paging();
		logic [7:0] p7;
		logic [7:0] ef;
		logic [7:0] v;
		rand_bits(8, p7);
		rand_bits(8, ef);
		ef = ef & 8'hFB;  // 1 MB mode stays on
		io_write(16'h7FFD, p7);
		io_write(16'hEFF7, ef);
		compare_byte("p7ffd", p7, p7ffd);
		compare_byte("peff7", ef, peff7);
		compare_page("pent1m_page", {p7[7:5], p7[2:0]}, pent1m_page);
		compare_bit("pent1m_1m_on", 1'b1, pent1m_1m_on);
		rand_bits(8, v);
		io_write(16'hFFFD, v);  // a15 high, not 7FFD
		compare_byte("p7ffd", p7, p7ffd);
		// lock bit first, then 128k mode
		rand_bits(8, p7);
		p7 = p7 | 8'h20;
		io_write(16'h7FFD, p7);
		rand_bits(8, ef);
		ef = ef | 8'h04;
		io_write(16'hEFF7, ef);
		rand_bits(8, v);
		io_write(16'h7FFD, v);  // locked out
		exp_peff7 = {ef[7], 1'b0, ef[5:4], 3'b000, ef[0]};
		compare_byte("p7ffd", {3'b000, p7[4:0]}, p7ffd);
		compare_byte("peff7", exp_peff7, peff7);
		compare_page("pent1m_page", {p7[7:5], p7[2:0]}, pent1m_page);
		compare_bit("pent1m_1m_on", 1'b0, pent1m_1m_on);
	endtask

	task automatic test_xt();
		logic [7:0] v;
		logic [7:0] wa;
		int         cnt;
		rand_bits(8, v);
		io_write(`ZP_XT_ADDR, zports_pkg::XT_BORDER);
		io_write(`ZP_XT_DATA, v);
		compare_border("border", v[5:0], border);
		rand_bits(8, v);
		io_write(`ZP_XT_ADDR, zports_pkg::XT_VCONFIG);
		io_write(`ZP_XT_DATA, v);
		compare_byte("vcfg", v, vcfg);
		rand_bits(8, wa);
		io_write(`ZP_XT_ADDR, zports_pkg::XT_PALADDR);
		io_write(`ZP_XT_DATA, wa);
		compare_byte("sp_wa", wa, sp_wa);
		// palette data write, watched cycle by cycle
		io_write(`ZP_XT_ADDR, zports_pkg::XT_PALDATA);
		rand_bits(8, v);
		@(negedge zclk);
		a      = `ZP_XT_DATA;
		din    = v;
		iorq_n = 1'b0;
		wr_n   = 1'b0;
		cnt    = 0;
		while (!sp_we && cnt < 10)
		begin
			@(negedge zclk);
			cnt++;
		end
		if (!sp_we)
			stop_run("timeout while waiting for the palette write strobe sp_we");
		@(negedge zclk);
		compare_bit("sp_we", 1'b0, sp_we);  // gone after one cycle
		@(negedge zclk);
		compare_bit("sp_we", 1'b0, sp_we);
		release_bus();
		repeat (2) @(negedge zclk);
		compare_byte("sp_wa", wa, sp_wa);
	endtask

	task automatic test_shadow();
		logic [7:0] v;
		logic [7:0] rd;
		logic       hit;
		logic       drv;
		dos = 1'b0;
		rand_bits(5, v);
		kj_in = v[4:0];
		rand_bits(8, v);
		mus_in = v;
		io_read({8'h00, `ZP_PORT_KJOY}, rd, hit, drv);
		compare_byte("dout", {3'b000, kj_in}, rd);
		compare_bit("porthit", 1'b1, hit);
		compare_bit("dataout", 1'b1, drv);
		io_read({8'hFA, `ZP_PORT_MOUSE}, rd, hit, drv);
		compare_byte("dout", mus_in, rd);
		dos = 1'b1;  // shadow hides 1F and F7
		io_read({8'h00, `ZP_PORT_KJOY}, rd, hit, drv);
		compare_bit("porthit", 1'b0, hit);
		compare_bit("dataout", 1'b0, drv);
		compare_byte("dout", `ZP_IDLE_BYTE, rd);
		rand_bits(8, v);
		io_write(16'hEFF7, v);
		compare_byte("peff7", exp_peff7, peff7);
		dos = 1'b0;
	endtask

	initial
	begin
		lfsr      = 32'hf36f_4f3f;
		exp_peff7 = 8'h00;
		rst_n     = 1'b0;
		din       = 8'h00;
		dos       = 1'b0;
		keys_in   = 5'h1F;  // no key pressed
		tape_read = 1'b0;
		kj_in     = 5'h00;
		mus_in    = 8'h00;
		release_bus();
		repeat (8) @(posedge zclk);
		@(negedge zclk);
		rst_n = 1'b1;
		test_reset();
		test_fe();
		test_paging();
		test_xt();
		test_shadow();
		$display("TEST PASS");
		$finish;
	end

endmodule

//--- zports.f
+incdir+include
design/zports_pkg.sv
design/io_access_if.sv
design/port_decode.sv
design/port_regs.sv
design/read_mux.sv
design/zports.sv
testbench/zports_props.sv
testbench/zports_tb.sv
